//--- hdl/pixFifo_consts.svh
// pixel fifo constants
`ifndef PIXFIFO_CONSTS_SVH
`define PIXFIFO_CONSTS_SVH

// ----------------------------------------
// buffer geometry
// ----------------------------------------
`define FIFO_DEPTH   256    // words, power of two
`define FIFO_ADDR_W  8      // log2 of depth
`define PIX_W        24     // rgb pixel word

// ----------------------------------------
// flow control and crossing
// ----------------------------------------
// free slots still left when full goes high, covers the writer's
// reaction lag and the pointer crossing delay
`define FULL_MARGIN  6

`define SYNC_STAGES  2      // flops per pointer crossing

`endif

//--- hdl/pixFifoPkg.sv
// pixel fifo types
`include "pixFifo_consts.svh"

package pixFifoPkg;

    // ----------------------------------------
    // plain vectors
    // ----------------------------------------
    typedef logic [`PIX_W-1:0]       pixWord;    // one pixel
    typedef logic [`FIFO_ADDR_W-1:0] fifoAddr;   // memory address
    typedef logic [`FIFO_ADDR_W:0]   fifoPtr;    // address plus wrap bit, binary or gray

    // ----------------------------------------
    // stage to memory requests
    // ----------------------------------------
    typedef struct packed {
        logic    en;        // write strobe, already gated by full
        fifoAddr addr;
        pixWord  data;
    } ramWrReq;

    typedef struct packed {
        logic    en;        // read strobe, already gated by empty
        fifoAddr addr;
    } ramRdReq;

endpackage

//--- hdl/grayPtrSync.sv
// gray pointer synchronizer
`include "pixFifo_consts.svh"

module grayPtrSync
(
    input  logic               iDstClk,    // receiving domain clock
    input  logic               rst,
    input  pixFifoPkg::fifoPtr ptrGray,    // from the other domain
    output pixFifoPkg::fifoPtr ptrBin      // binary, local domain
);

    localparam int PtrW = $bits(pixFifoPkg::fifoPtr);

    pixFifoPkg::fifoPtr syncReg [`SYNC_STAGES];    // metastability chain
    pixFifoPkg::fifoPtr binComb;                   // decoded last stage

    // ----------------------------------------
    // shift chain plus decode register
    // ----------------------------------------
    always_ff @(posedge iDstClk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `SYNC_STAGES; i++)
                syncReg[i] <= '0;
            ptrBin <= '0;
        end
        else
        begin
            syncReg[0] <= ptrGray;    // only one bit changes per step
            for (int i = 1; i < `SYNC_STAGES; i++)
                syncReg[i] <= syncReg[i-1];
            ptrBin <= binComb;
        end
    end

    // gray to binary, running xor from the msb down
    always_comb
    begin
        binComb[PtrW-1] = syncReg[`SYNC_STAGES-1][PtrW-1];
        for (int i = PtrW - 2; i >= 0; i--)
            binComb[i] = binComb[i+1] ^ syncReg[`SYNC_STAGES-1][i];
    end

endmodule

//--- hdl/fifoWritePort.sv
// fifo write side control
`include "pixFifo_consts.svh"

module fifoWritePort
(
    input  logic                iSrcClk,
    input  logic                rst,
    input  pixFifoPkg::pixWord  wrData,       // pixel in
    input  logic                we,           // write strobe
    output logic                full,         // early full, registered
    input  pixFifoPkg::fifoPtr  rdPtrSync,    // read pointer seen here, binary
    output pixFifoPkg::fifoPtr  wrPtrGray,    // to the read side crossing
    output pixFifoPkg::ramWrReq wrReq         // memory write port
);

    // ----------------------------------------
    // full threshold
    // ----------------------------------------
    // depth minus margin, full once this many words are held
    localparam pixFifoPkg::fifoPtr FullLevel =
        pixFifoPkg::fifoPtr'(`FIFO_DEPTH - `FULL_MARGIN);

    pixFifoPkg::fifoPtr wrPtrBin;     // current write slot
    pixFifoPkg::fifoPtr wrPtrNext;    // pointer after this edge
    pixFifoPkg::fifoPtr fillNext;     // occupancy after this edge
    logic               wrAccept;     // write taken this cycle

    // writes while full are simply dropped
    assign wrAccept  = we & ~full;
    assign wrPtrNext = wrPtrBin + pixFifoPkg::fifoPtr'(wrAccept);

    // wrap bit keeps the difference correct across the turnover,
    // read pointer here is stale so occupancy is an upper bound
    assign fillNext  = wrPtrNext - rdPtrSync;

    // ----------------------------------------
    // pointer, gray copy and flag
    // ----------------------------------------
    always_ff @(posedge iSrcClk)
    begin
        if (rst)
        begin
            wrPtrBin  <= '0;
            wrPtrGray <= '0;
            full      <= 1'b0;
        end
        else
        begin
            wrPtrBin  <= wrPtrNext;
            wrPtrGray <= wrPtrNext ^ (wrPtrNext >> 1);    // gray of the new pointer
            full      <= (fillNext >= FullLevel);         // margin slots still free
        end
    end

    // ----------------------------------------
    // memory request
    // ----------------------------------------
    // written on the same edge the pointer moves, so the word is
    // in the array long before the gray pointer lands on the other side
    always_comb
    begin
        wrReq.en   = wrAccept;
        wrReq.addr = wrPtrBin[`FIFO_ADDR_W-1:0];    // drop wrap bit
        wrReq.data = wrData;
    end

endmodule

//--- hdl/dualPortRam.sv
// fifo pixel memory
`include "pixFifo_consts.svh"

module dualPortRam
(
    input  logic                iSrcClk,    // write clock
    input  logic                iDstClk,    // read clock
    input  pixFifoPkg::ramWrReq wrReq,
    input  pixFifoPkg::ramRdReq rdReq,
    output pixFifoPkg::pixWord  rdWord      // registered read data
);

    pixFifoPkg::pixWord mem [`FIFO_DEPTH];    // simple dual port block

    // ----------------------------------------
    // write port, source domain
    // ----------------------------------------
    always_ff @(posedge iSrcClk)
    begin
        if (wrReq.en)
            mem[wrReq.addr] <= wrReq.data;
    end

    // ----------------------------------------
    // read port, destination domain
    // ----------------------------------------
    // output register with enable, maps onto the ram's own register
    always_ff @(posedge iDstClk)
    begin
        if (rdReq.en)
            rdWord <= mem[rdReq.addr];    // holds between reads
    end

endmodule

//--- hdl/fifoReadPort.sv
// fifo read side control
`include "pixFifo_consts.svh"

module fifoReadPort
(
    input  logic                iDstClk,
    input  logic                rst,
    input  logic                re,           // read strobe
    output logic                empty,        // registered
    input  pixFifoPkg::fifoPtr  wrPtrSync,    // write pointer seen here, binary
    output pixFifoPkg::fifoPtr  rdPtrGray,    // to the write side crossing
    output pixFifoPkg::ramRdReq rdReq,        // memory read port
    input  pixFifoPkg::pixWord  rdWord,       // memory output register
    output pixFifoPkg::pixWord  rdData,       // pixel out
    output logic                rdValid       // one cycle per word
);

    pixFifoPkg::fifoPtr rdPtrBin;      // next slot to read
    pixFifoPkg::fifoPtr rdPtrNext;     // pointer after this edge
    logic               rdAccept;      // read taken this cycle
    logic               validStage;    // word sits in the memory register

    // reads while empty are ignored
    assign rdAccept  = re & ~empty;
    assign rdPtrNext = rdPtrBin + pixFifoPkg::fifoPtr'(rdAccept);

    // ----------------------------------------
    // pointer, gray copy and empty flag
    // ----------------------------------------
    always_ff @(posedge iDstClk)
    begin
        if (rst)
        begin
            rdPtrBin  <= '0;
            rdPtrGray <= '0;
            empty     <= 1'b1;
        end
        else
        begin
            rdPtrBin  <= rdPtrNext;
            rdPtrGray <= rdPtrNext ^ (rdPtrNext >> 1);
            // compare ahead so the flag is right in the following cycle,
            // a late write pointer only makes it pessimistic
            empty     <= (rdPtrNext == wrPtrSync);
        end
    end

    // ----------------------------------------
    // valid pipeline
    // ----------------------------------------
    // stage 1 marks the memory register loaded, stage 2 is the output
    always_ff @(posedge iDstClk)
    begin
        if (rst)
        begin
            validStage <= 1'b0;
            rdValid    <= 1'b0;
        end
        else
        begin
            validStage <= rdAccept;
            rdValid    <= validStage;
        end
    end

    // output word, kept until the next valid
    always_ff @(posedge iDstClk)
    begin
        if (validStage)
            rdData <= rdWord;
    end

    // ----------------------------------------
    // memory request
    // ----------------------------------------
    always_comb
    begin
        rdReq.en   = rdAccept;
        rdReq.addr = rdPtrBin[`FIFO_ADDR_W-1:0];    // drop wrap bit
    end

endmodule

//--- hdl/pixCdcFifo.sv
// dual clock pixel fifo

module pixCdcFifo
(
    // write side, iSrcClk
    input  logic               iSrcClk,
    input  pixFifoPkg::pixWord wrData,
    input  logic               we,
    output logic               full,

    // read side, iDstClk
    input  logic               iDstClk,
    input  logic               re,
    output pixFifoPkg::pixWord rdData,
    output logic               rdValid,
    output logic               empty,

    input  logic               rst          // sync, seen by both clocks
);

    // ----------------------------------------
    // internal nets
    // ----------------------------------------
    pixFifoPkg::ramWrReq wrReq;         // write port to memory
    pixFifoPkg::ramRdReq rdReq;         // read port to memory
    pixFifoPkg::pixWord  rdWord;        // memory read register
    pixFifoPkg::fifoPtr  wrPtrGray;     // source domain
    pixFifoPkg::fifoPtr  rdPtrGray;     // destination domain
    pixFifoPkg::fifoPtr  wrPtrSync;     // write pointer in dst domain
    pixFifoPkg::fifoPtr  rdPtrSync;     // read pointer in src domain

    // ----------------------------------------
    // write stage
    // ----------------------------------------
    fifoWritePort i_fifoWritePort
    (
        .iSrcClk   (iSrcClk),
        .rst       (rst),
        .wrData    (wrData),
        .we        (we),
        .full      (full),
        .rdPtrSync (rdPtrSync),
        .wrPtrGray (wrPtrGray),
        .wrReq     (wrReq)
    );

    // ----------------------------------------
    // storage
    // ----------------------------------------
    dualPortRam i_dualPortRam
    (
        .iSrcClk (iSrcClk),
        .iDstClk (iDstClk),
        .wrReq   (wrReq),
        .rdReq   (rdReq),
        .rdWord  (rdWord)
    );

    // ----------------------------------------
    // read stage and output register
    // ----------------------------------------
    fifoReadPort i_fifoReadPort
    (
        .iDstClk   (iDstClk),
        .rst       (rst),
        .re        (re),
        .empty     (empty),
        .wrPtrSync (wrPtrSync),
        .rdPtrGray (rdPtrGray),
        .rdReq     (rdReq),
        .rdWord    (rdWord),
        .rdData    (rdData),
        .rdValid   (rdValid)
    );

    // ----------------------------------------
    // pointer crossings
    // ----------------------------------------
    grayPtrSync i_wrPtrSync             // src to dst
    (
        .iDstClk (iDstClk),
        .rst     (rst),
        .ptrGray (wrPtrGray),
        .ptrBin  (wrPtrSync)
    );

    grayPtrSync i_rdPtrSync             // dst to src, clocked on the writer
    (
        .iDstClk (iSrcClk),
        .rst     (rst),
        .ptrGray (rdPtrGray),
        .ptrBin  (rdPtrSync)
    );

endmodule

//--- bench/pixCdcFifo_properties.sv
// pixel fifo timing checks

module pixCdcFifo_properties
(
    input logic iSrcClk,
    input logic iDstClk,
    input logic rst,
    input logic full,
    input logic re,
    input logic empty,
    input logic rdValid
);

    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;    // read by the testbench at the end

    // ----------------------------------------
    // state while and after reset
    // ----------------------------------------
    resetDstState: assert property (@(posedge iDstClk) rst |=> (empty && !rdValid))
        else begin failCount++; $error("read side not idle after reset"); end

    resetSrcState: assert property (@(posedge iSrcClk) rst |=> !full)
        else begin failCount++; $error("full high after reset"); end

    // ----------------------------------------
    // read latency, fixed two cycles
    // ----------------------------------------
    validAfterRead: assert property (@(posedge iDstClk) disable iff (rst)
        (re && !empty) |-> ##2 rdValid)
        else begin failCount++; $error("accepted read gave no valid two cycles later"); end

    // every valid traces back to one accepted read
    validHasRead: assert property (@(posedge iDstClk) disable iff (rst)
        rdValid |-> $past(re && !empty, 2))
        else begin failCount++; $error("valid without an accepted read"); end

    noValidWhenEmpty: assert property (@(posedge iDstClk) disable iff (rst)
        (re && empty) |-> ##2 !rdValid)    // ignored read
        else begin failCount++; $error("read while empty produced a valid"); end

endmodule

// attach to every instance of the top level
bind pixCdcFifo pixCdcFifo_properties i_pixCdcFifoProps
(
    .iSrcClk (iSrcClk),
    .iDstClk (iDstClk),
    .rst     (rst),
    .full    (full),
    .re      (re),
    .empty   (empty),
    .rdValid (rdValid)
);

//--- bench/pixCdcFifo_tb.sv
// pixel fifo testbench
`include "pixFifo_consts.svh"

module pixCdcFifo_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int WaitLimit     = 4 * `FIFO_DEPTH;    // cycles per wait loop
    localparam int TrafficCycles = 1500;               // src cycles of mixed traffic
    localparam int MinBurst      = `FIFO_DEPTH - `FULL_MARGIN - 3;

    logic               iSrcClk;
    logic               iDstClk;
    logic               rst;
    pixFifoPkg::pixWord wrData;
    logic               we;
    logic               full;
    logic               re;
    pixFifoPkg::pixWord rdData;
    logic               rdValid;
    logic               empty;

    pixFifoPkg::pixWord expQueue [$];    // accepted writes, oldest first
    int unsigned        lcgState    = 18;
    int                 acceptCount = 0;
    int                 dataErrors  = 0;
    int                 checkErrors = 0;
    int                 timeouts    = 0;
    logic               writerDone;

    pixCdcFifo i_pixCdcFifo
    (
        .iSrcClk (iSrcClk),
        .wrData  (wrData),
        .we      (we),
        .full    (full),
        .iDstClk (iDstClk),
        .re      (re),
        .rdData  (rdData),
        .rdValid (rdValid),
        .empty   (empty),
        .rst     (rst)
    );

    initial
    begin
        iDstClk = 1'b0;
        forever #50 iDstClk = ~iDstClk;    // 100 ns
    end

    initial
    begin
        iSrcClk = 1'b0;
        forever #35 iSrcClk = ~iSrcClk;    // 70 ns, edges never meet dst edges
    end

    function automatic logic [15:0] lcgNext();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[30:15];    // upper bits, better period
    endfunction

    function automatic pixFifoPkg::pixWord randomWord();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = lcgNext();
        lo = lcgNext();
        return {hi, lo[7:0]};
    endfunction

    // ----------------------------------------
    // scoreboard
    // ----------------------------------------
    always @(posedge iSrcClk)
    begin
        if (!rst && we && !full)
        begin
            expQueue.push_back(wrData);
            acceptCount++;
            assert (expQueue.size() <= `FIFO_DEPTH)    // includes reads in flight
            else
            begin
                checkErrors++;
                $display("write accepted with more than the depth in the FIFO");
            end
        end
    end

    always @(posedge iDstClk)
    begin
        pixFifoPkg::pixWord expWord;
        if (!rst && rdValid)
        begin
            if (expQueue.size() == 0)
            begin
                checkErrors++;
                $display("valid word came out with no write left to match it");
            end
            else
            begin
                expWord = expQueue.pop_front();
                assert (rdData == expWord)
                else
                begin
                    dataErrors++;
                    $display("** Error [dataOrder] expected %06h actual %06h", expWord, rdData);
                end
            end
        end
    end

    // ----------------------------------------
    // run control
    // ----------------------------------------
    task automatic closeRun();
        int propFails;
        propFails = i_pixCdcFifo.i_pixCdcFifoProps.failCount;
        $display("data errors %0d, check errors %0d, assertion failures %0d, timeouts %0d",
                 dataErrors, checkErrors, propFails, timeouts);
        if (dataErrors + checkErrors + propFails + timeouts == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    endtask

    task automatic abortOnTimeout(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
        closeRun();
    endtask

    // reads with nothing stored, no valid may follow
    task automatic readWhileEmpty();
        for (int i = 0; i < 8; i++)
        begin
            @(posedge iDstClk);
            re <= 1'b1;
            assert (empty)
            else
            begin
                checkErrors++;
                $display("** Error [readEmpty] expected empty 1 actual %0b", empty);
            end
        end
        @(posedge iDstClk);
        re <= 1'b0;
    endtask

    // writes only, until full shows up
    task automatic fullBurst();
        int startCount;
        int taken;
        int cycles;
        startCount = acceptCount;
        cycles     = 0;
        @(posedge iSrcClk);
        while (!full && cycles < WaitLimit)
        begin
            we     <= 1'b1;
            wrData <= randomWord();
            @(posedge iSrcClk);
            cycles++;
        end
        if (!full)
            abortOnTimeout("full during the write burst");
        taken = acceptCount - startCount;
        for (int i = 0; i < 4; i++)    // keep pushing, these must be dropped
        begin
            wrData <= randomWord();
            @(posedge iSrcClk);
        end
        we <= 1'b0;
        assert (taken >= MinBurst && taken < `FIFO_DEPTH)
        else
        begin
            checkErrors++;
            $display("** Error [fullMargin] expected %0d to %0d writes actual %0d",
                     MinBurst, `FIFO_DEPTH - 1, taken);
        end
    endtask

    // read until every accepted word came back
    task automatic drainAll();
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < WaitLimit)
        begin
            @(posedge iDstClk);
            re <= 1'b1;
            @(negedge iDstClk);    // queue settled here
            done = (expQueue.size() == 0);
            cycles++;
        end
        @(posedge iDstClk);
        re <= 1'b0;
        if (!done)
            abortOnTimeout("the FIFO to drain");
    endtask

    // empty must rise, then hold with random reads and no writes
    task automatic emptyHold();
        int          cycles;
        logic [15:0] rnd;
        cycles = 0;
        while (!empty && cycles < WaitLimit)
        begin
            @(posedge iDstClk);
            cycles++;
        end
        if (!empty)
            abortOnTimeout("empty after the drain");
        for (int i = 0; i < 12; i++)
        begin
            @(posedge iDstClk);
            rnd = lcgNext();
            re  <= rnd[0];
            assert (empty)
            else
            begin
                checkErrors++;
                $display("** Error [emptyHold] expected empty 1 actual %0b", empty);
            end
        end
        re <= 1'b0;
    endtask

    // writer faster than reader, so full gets hit too
    task automatic randomTraffic();
        logic [15:0] rnd;
        writerDone = 1'b0;
        fork
            begin
                for (int i = 0; i < TrafficCycles; i++)
                begin
                    @(posedge iSrcClk);
                    we     <= (lcgNext() % 8) < 5;
                    wrData <= randomWord();
                end
                @(posedge iSrcClk);
                we         <= 1'b0;
                writerDone = 1'b1;
            end
            begin
                for (int n = 0; !writerDone && n < 2 * TrafficCycles; n++)
                begin
                    @(posedge iDstClk);
                    rnd = lcgNext();
                    re  <= rnd[3];    // about half the cycles
                end
                if (!writerDone)
                    abortOnTimeout("the random writer to finish");
            end
        join
    endtask

    // ----------------------------------------
    // sequence
    // ----------------------------------------
    initial
    begin
        rst        = 1'b1;
        we         = 1'b0;
        re         = 1'b0;
        wrData     = '0;
        writerDone = 1'b0;
        for (int i = 0; i < 16; i++)    // covers 22 src cycles as well
            @(posedge iDstClk);
        rst <= 1'b0;

        readWhileEmpty();
        fullBurst();
        drainAll();
        emptyHold();
        randomTraffic();    // refill with both clocks busy
        drainAll();
        emptyHold();

        for (int i = 0; i < 4; i++)
            @(posedge iDstClk);
        closeRun();
    end

endmodule

//--- list.f
+incdir+hdl
hdl/pixFifoPkg.sv
hdl/grayPtrSync.sv
hdl/fifoWritePort.sv
hdl/dualPortRam.sv
hdl/fifoReadPort.sv
hdl/pixCdcFifo.sv
bench/pixCdcFifo_properties.sv
bench/pixCdcFifo_tb.sv
